//--- Makefile
# Verilator flow for the AMO unit testbench
TOP := amoUnitTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f amoUnit.f --top-module $(TOP) -Mdir obj_dir -o simv
	./obj_dir/simv > sim.log 2>&1 ; cat sim.log
	grep -q "sim passed" sim.log

lint:
	verilator --lint-only --timing --assert -f amoUnit.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- amoUnit.f
source/amoPkg.sv
source/amoAlu.sv
source/amoDataMem.sv
source/amoSequencer.sv
source/amoUnit.sv
tests/amoClockGen.sv
tests/amoUnit_properties.sv
tests/amoUnitTb.sv

//--- source/amoAlu.sv
// Combinational AMO ALU, builds the word written back from the old word and the operand
`timescale 1ns/1ps

module amoAlu
(
	input amoPkg::amoOp_e op,
	input amoPkg::laneSize_e laneSize,
	input logic [amoPkg::dataWidth-1:0] oldData,
	input logic [amoPkg::dataWidth-1:0] operand,
	output logic [amoPkg::dataWidth-1:0] newData
);

	import amoPkg::*;

	// One lane-wise result per lane size
	logic [dataWidth-1:0] laneRes [laneKinds];

	// Result picked by the requested lane size
	logic [dataWidth-1:0] laneSel;

	// ====================
	// Lane-wise operations
	// ====================

	// Every lane size is built in parallel and selected afterwards.
	// No carry or shifted bit crosses a lane boundary.
	for (genvar s = 0; s < laneKinds; s++)
	begin : gSize
		localparam int laneW = byteWidth << s;
		localparam int shW = 3 + s;
		localparam int nLanes = dataWidth / laneW;

		// Shift amount comes from the low operand bits only,
		// the same amount for every lane
		logic [shW-1:0] shAmt;

		assign shAmt = operand[shW-1:0];

		for (genvar l = 0; l < nLanes; l++)
		begin : gLane
			logic [laneW-1:0] a;
			logic [laneW-1:0] b;
			logic [laneW-1:0] r;
			logic sLess;
			logic uLess;

			assign a = oldData[l*laneW +: laneW];
			assign b = operand[l*laneW +: laneW];

			// Old lane below operand lane
			assign sLess = $signed(a) < $signed(b);
			assign uLess = a < b;

			always_comb
			begin
				case (op)
					amoAdd:
					begin
						r = a + b;
					end
					amoShl:
					begin
						r = a << shAmt;
					end
					amoShr:
					begin
						r = a >> shAmt;
					end
					amoMin:
					begin
						r = sLess ? a : b;
					end
					amoMax:
					begin
						r = sLess ? b : a;
					end
					amoMinU:
					begin
						r = uLess ? a : b;
					end
					amoMaxU:
					begin
						r = uLess ? b : a;
					end
					default:
					begin
						// Full-word ops are handled below
						r = a;
					end
				endcase
			end

			assign laneRes[s][l*laneW +: laneW] = r;
		end
	end

	// ====================
	// Result select
	// ====================

	always_comb
	begin
		case (laneSize)
			laneByte:
			begin
				laneSel = laneRes[0];
			end
			laneHalf:
			begin
				laneSel = laneRes[1];
			end
			laneWord:
			begin
				laneSel = laneRes[2];
			end
			default:
			begin
				laneSel = laneRes[3];
			end
		endcase
	end

	// Swap and the logic ops ignore the lane size
	always_comb
	begin
		case (op)
			amoSwap:
			begin
				newData = operand;
			end
			amoAnd:
			begin
				newData = oldData & operand;
			end
			amoOr:
			begin
				newData = oldData | operand;
			end
			amoXor:
			begin
				newData = oldData ^ operand;
			end
			default:
			begin
				newData = laneSel;
			end
		endcase
	end

endmodule

//--- source/amoDataMem.sv
// Local data memory of the AMO unit, one registered read port and one write port
`timescale 1ns/1ps

module amoDataMem
(
	input logic clk,
	input logic [amoPkg::addrWidth-1:0] rdAddr,
	output logic [amoPkg::dataWidth-1:0] rdData,
	input logic we,
	input logic [amoPkg::addrWidth-1:0] wrAddr,
	input logic [amoPkg::dataWidth-1:0] wrData
);

	import amoPkg::*;

	// Storage, contents undefined until written
	logic [dataWidth-1:0] mem [memDepth];

	// Write on the clock edge
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[wrAddr] <= wrData;
		end
	end

	// Registered read; a read and write to the same word
	// in one cycle returns the word as it was before the write
	always_ff @(posedge clk)
	begin
		rdData <= mem[rdAddr];
	end

endmodule

//--- source/amoPkg.sv
// Shared sizes, enums and the request type, imported by every module of the AMO unit
package amoPkg;

	// ====================
	// Sizes
	// ====================

	// Width of one memory word and of a request operand
	localparam int dataWidth = 64;

	// Local data memory geometry
	localparam int memDepth = 64;
	localparam int addrWidth = 6;

	// Narrowest lane, and how many lane sizes exist (8, 16, 32, 64)
	localparam int byteWidth = 8;
	localparam int laneKinds = 4;

	// ====================
	// Encodings
	// ====================

	// Read-modify-write operations
	typedef enum logic [3:0]
	{
		amoSwap,
		amoAdd,
		amoAnd,
		amoOr,
		amoXor,
		amoShl,
		amoShr,
		amoMin,
		amoMax,
		amoMinU,
		amoMaxU
	} amoOp_e;

	// Lane size used by add, shifts and min/max
	typedef enum logic [1:0]
	{
		laneByte,
		laneHalf,
		laneWord,
		laneDouble
	} laneSize_e;

	// Sequencer states, one per cycle of an AMO
	typedef enum logic [1:0]
	{
		stIdle,
		stRead,
		stWrite,
		stDone
	} amoState_e;

	// Decoded request as it arrives with the start strobe
	typedef struct packed
	{
		amoOp_e op;
		laneSize_e laneSize;
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] operand;
	} amoReq_t;

endpackage

//--- source/amoSequencer.sv
// AMO control FSM, steps each request through read, write-back and done, and arbitrates host writes
`timescale 1ns/1ps

module amoSequencer
(
	input logic clk,
	input logic arstN,

	// Request side
	input logic start,
	input amoPkg::amoReq_t req,

	// Host preload port
	input logic hostWe,
	input logic [amoPkg::addrWidth-1:0] hostAddr,
	input logic [amoPkg::dataWidth-1:0] hostData,

	// Memory read port
	output logic [amoPkg::addrWidth-1:0] rdAddr,
	input logic [amoPkg::dataWidth-1:0] rdData,

	// ALU result and memory write port
	input logic [amoPkg::dataWidth-1:0] newData,
	output logic memWe,
	output logic [amoPkg::addrWidth-1:0] memAddr,
	output logic [amoPkg::dataWidth-1:0] memData,

	// ALU controls
	output amoPkg::amoOp_e aluOp,
	output amoPkg::laneSize_e aluLane,
	output logic [amoPkg::dataWidth-1:0] aluOperand,

	// Response
	output logic busy,
	output logic done,
	output logic [amoPkg::dataWidth-1:0] oldData
);

	import amoPkg::*;

	amoState_e state;
	amoState_e stateNext;

	// Request held for the whole operation
	amoReq_t reqQ;

	logic accept;

	// ====================
	// State machine
	// ====================

	// A start while busy is dropped
	assign accept = (state == stIdle) && start;

	always_comb
	begin
		stateNext = state;
		case (state)
			stIdle:
			begin
				if (accept)
				begin
					stateNext = stRead;
				end
			end
			stRead:
			begin
				stateNext = stWrite;
			end
			stWrite:
			begin
				stateNext = stDone;
			end
			default:
			begin
				stateNext = stIdle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stIdle;
		end
		else
		begin
			state <= stateNext;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			reqQ <= req;
		end
	end

	// ====================
	// Datapath control
	// ====================

	// Read address is presented in stRead, data arrives for stWrite
	assign rdAddr = reqQ.addr;

	assign aluOp = reqQ.op;
	assign aluLane = reqQ.laneSize;
	assign aluOperand = reqQ.operand;

	// Write-back owns the port in stWrite, host gets it only when idle and no start
	always_comb
	begin
		if (state == stWrite)
		begin
			memWe = 1'b1;
			memAddr = reqQ.addr;
			memData = newData;
		end
		else
		begin
			memWe = hostWe && (state == stIdle) && !start;
			memAddr = hostAddr;
			memData = hostData;
		end
	end

	// Old word is kept for the response
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			oldData <= '0;
		end
		else if (state == stWrite)
		begin
			oldData <= rdData;
		end
	end

	assign busy = (state != stIdle);
	assign done = (state == stDone);

endmodule

//--- source/amoUnit.sv
// Top level of the atomic memory operation unit, ties sequencer, data memory and AMO ALU together
`timescale 1ns/1ps

module amoUnit
(
	input logic clk,
	input logic arstN,

	// Request and response
	input logic start,
	input amoPkg::amoReq_t req,
	output logic busy,
	output logic done,
	output logic [amoPkg::dataWidth-1:0] oldData,

	// Host preload
	input logic hostWe,
	input logic [amoPkg::addrWidth-1:0] hostAddr,
	input logic [amoPkg::dataWidth-1:0] hostData
);

	import amoPkg::*;

	// Memory read path
	logic [addrWidth-1:0] rdAddr;
	logic [dataWidth-1:0] rdData;

	// Memory write path
	logic memWe;
	logic [addrWidth-1:0] memAddr;
	logic [dataWidth-1:0] memData;

	// ALU controls and result
	amoOp_e aluOp;
	laneSize_e aluLane;
	logic [dataWidth-1:0] aluOperand;
	logic [dataWidth-1:0] newData;

	amoSequencer amoSequencer_i
	(
		.clk(clk),
		.arstN(arstN),
		.start(start),
		.req(req),
		.hostWe(hostWe),
		.hostAddr(hostAddr),
		.hostData(hostData),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.newData(newData),
		.memWe(memWe),
		.memAddr(memAddr),
		.memData(memData),
		.aluOp(aluOp),
		.aluLane(aluLane),
		.aluOperand(aluOperand),
		.busy(busy),
		.done(done),
		.oldData(oldData)
	);

	amoDataMem amoDataMem_i
	(
		.clk(clk),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.we(memWe),
		.wrAddr(memAddr),
		.wrData(memData)
	);

	amoAlu amoAlu_i
	(
		.op(aluOp),
		.laneSize(aluLane),
		.oldData(rdData),
		.operand(aluOperand),
		.newData(newData)
	);

endmodule

//--- tests/amoClockGen.sv
// Free-running testbench clock with an 8 ns period, instantiated by the AMO unit testbench
`timescale 1ns/1ps

module amoClockGen
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			// Half period
			#4 clk = ~clk;
		end
	end

endmodule

//--- tests/amoUnitTb.sv
// Directed testbench for the AMO unit, checks every operation against a shadow memory model
`timescale 1ns/1ps

module amoUnitTb;

	import amoPkg::*;

	logic clk;
	logic arstN;
	logic start;
	amoReq_t req;
	logic busy;
	logic done;
	logic [dataWidth-1:0] oldData;
	logic hostWe;
	logic [addrWidth-1:0] hostAddr;
	logic [dataWidth-1:0] hostData;

	// Shadow copy of the data memory
	logic [dataWidth-1:0] model [memDepth];
	int failCount;

	amoClockGen clkGen_i
	(
		.clk(clk)
	);

	amoUnit amoUnit_i
	(
		.clk(clk),
		.arstN(arstN),
		.start(start),
		.req(req),
		.busy(busy),
		.done(done),
		.oldData(oldData),
		.hostWe(hostWe),
		.hostAddr(hostAddr),
		.hostData(hostData)
	);

	// ====================
	// Reference model
	// ====================

	// One bit set in every lane, at the top or at the bottom
	function automatic logic [dataWidth-1:0] laneBits(laneSize_e ls, logic top);
		int w;
		logic [dataWidth-1:0] pat;
		w = 8 << int'(ls);
		pat = '0;
		for (int i = 0; i < dataWidth / w; i++)
		begin
			pat = pat | (64'd1 << (i * w + (top ? w - 1 : 0)));
		end
		return pat;
	endfunction

	// New memory word after one AMO
	function automatic logic [dataWidth-1:0] predictWord(amoOp_e op, laneSize_e ls,
		logic [dataWidth-1:0] a, logic [dataWidth-1:0] b);
		int w;
		int sh;
		logic [dataWidth-1:0] mask;
		logic [dataWidth-1:0] sign;
		logic [dataWidth-1:0] x;
		logic [dataWidth-1:0] y;
		logic [dataWidth-1:0] r;
		logic [dataWidth-1:0] res;
		if (op == amoSwap)
		begin
			return b;
		end
		if (op == amoAnd)
		begin
			return a & b;
		end
		if (op == amoOr)
		begin
			return a | b;
		end
		if (op == amoXor)
		begin
			return a ^ b;
		end
		w = 8 << int'(ls);
		mask = (w == dataWidth) ? '1 : ((64'd1 << w) - 64'd1);
		sign = 64'd1 << (w - 1);
		// Shift amount from the low operand bits that fit the lane
		sh = int'(b & 64'(w - 1));
		res = '0;
		for (int i = 0; i < dataWidth / w; i++)
		begin
			x = (a >> (i * w)) & mask;
			y = (b >> (i * w)) & mask;
			case (op)
				amoAdd: r = (x + y) & mask;
				amoShl: r = (x << sh) & mask;
				amoShr: r = x >> sh;
				// Flipping the sign bit turns a signed order into an unsigned one
				amoMin: r = ((x ^ sign) < (y ^ sign)) ? x : y;
				amoMax: r = ((x ^ sign) < (y ^ sign)) ? y : x;
				amoMinU: r = (x < y) ? x : y;
				default: r = (x < y) ? y : x;
			endcase
			res = res | (r << (i * w));
		end
		return res;
	endfunction

	// ====================
	// Checks
	// ====================

	task automatic abortRun();
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkData(string name, logic [dataWidth-1:0] got, logic [dataWidth-1:0] exp);
		if (got !== exp)
		begin
			failCount++;
			$display("CHECK FAILED time %0t: %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkLevel(string name, logic got, logic exp);
		if (got !== exp)
		begin
			failCount++;
			$display("CHECK FAILED time %0t: %s got %b expected %b", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkCycles(string name, int got, int exp);
		if (got != exp)
		begin
			failCount++;
			$display("CHECK FAILED time %0t: %s got %0d expected %0d", $time, name, got, exp);
			abortRun();
		end
	endtask

	// ====================
	// Drivers
	// ====================

	task automatic hostWrite(logic [addrWidth-1:0] addr, logic [dataWidth-1:0] data);
		@(posedge clk);
		hostWe <= 1'b1;
		hostAddr <= addr;
		hostData <= data;
		@(posedge clk);
		hostWe <= 1'b0;
		model[addr] = data;
	endtask

	// Start is high for one edge, returns right after the edge that samples it
	task automatic sendStart(amoReq_t r);
		@(posedge clk);
		start <= 1'b1;
		req <= r;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Counts falling edges until done is seen
	task automatic awaitDone(output int cycles);
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
			if (cycles > 16)
			begin
				$display("Timeout: done never rose after the request");
				abortRun();
			end
		end
		while (!done);
	endtask

	task automatic runAmo(amoOp_e op, laneSize_e ls, logic [addrWidth-1:0] addr,
		logic [dataWidth-1:0] operand);
		int cycles;
		logic [dataWidth-1:0] expOld;
		expOld = model[addr];
		sendStart('{op: op, laneSize: ls, addr: addr, operand: operand});
		awaitDone(cycles);
		checkCycles("done latency", cycles, 3);
		checkLevel("busy", busy, 1'b1);
		checkData("oldData", oldData, expOld);
		model[addr] = predictWord(op, ls, expOld, operand);
	endtask

	// Returns the stored word and leaves it unchanged
	task automatic readBack(logic [addrWidth-1:0] addr);
		runAmo(amoOr, laneDouble, addr, '0);
	endtask

	// ====================
	// Tests
	// ====================

	task automatic testResetAndSwap();
		logic [dataWidth-1:0] first;
		@(negedge clk);
		checkLevel("busy", busy, 1'b0);
		checkLevel("done", done, 1'b0);
		checkData("oldData", oldData, '0);
		for (int i = 0; i < memDepth; i++)
		begin
			hostWrite(addrWidth'(i), {$urandom, $urandom});
		end
		first = {$urandom, $urandom};
		hostWrite(6'd5, 64'h0123_4567_89AB_CDEF);
		runAmo(amoSwap, laneDouble, 6'd5, first);
		runAmo(amoSwap, laneByte, 6'd5, {$urandom, $urandom});
	endtask

	task automatic testAddLanes();
		laneSize_e ls;
		for (int s = 0; s < 4; s++)
		begin
			ls = laneSize_e'(2'(s));
			// Every lane wraps from all ones to zero
			hostWrite(6'd12, '1);
			runAmo(amoAdd, ls, 6'd12, laneBits(ls, 1'b0));
			readBack(6'd12);
			repeat (3) runAmo(amoAdd, ls, 6'd13, {$urandom, $urandom});
		end
		readBack(6'd13);
	endtask

	task automatic testLogicAndShifts();
		laneSize_e ls;
		runAmo(amoAnd, laneByte, 6'd14, {$urandom, $urandom});
		runAmo(amoOr, laneHalf, 6'd14, {$urandom, $urandom});
		runAmo(amoXor, laneWord, 6'd14, {$urandom, $urandom});
		readBack(6'd14);
		for (int s = 0; s < 4; s++)
		begin
			ls = laneSize_e'(2'(s));
			hostWrite(6'd15, {$urandom, $urandom});
			runAmo(amoShl, ls, 6'd15, 64'hFFFF_FFFF_FFFF_FFE3);
			runAmo(amoShr, ls, 6'd15, {$urandom, $urandom});
			runAmo(amoShr, ls, 6'd15, 64'h8000_0000_0000_0021);
			readBack(6'd15);
		end
	endtask

	task automatic testMinMax();
		laneSize_e ls;
		amoOp_e op;
		for (int s = 0; s < 4; s++)
		begin
			ls = laneSize_e'(2'(s));
			for (int k = 0; k < 4; k++)
			begin
				op = amoOp_e'(4'(int'(amoMin) + k));
				// Top bit set against one so signed and unsigned orders disagree
				hostWrite(6'd30, laneBits(ls, 1'b1));
				runAmo(op, ls, 6'd30, laneBits(ls, 1'b0));
				readBack(6'd30);
				runAmo(op, ls, 6'd31, {$urandom, $urandom});
			end
		end
		readBack(6'd31);
	endtask

	task automatic testBusyRules();
		int cycles;
		logic [dataWidth-1:0] expOld;
		logic [dataWidth-1:0] operand;
		expOld = model[10];
		operand = {$urandom, $urandom};
		@(posedge clk);
		start <= 1'b1;
		req <= '{op: amoAdd, laneSize: laneHalf, addr: 6'd10, operand: operand};
		// Host write driven at edge 0 is seen only while busy
		@(posedge clk);
		start <= 1'b0;
		hostWe <= 1'b1;
		hostAddr <= 6'd11;
		hostData <= ~model[11];
		// Second start driven at edge 1 must be dropped
		@(posedge clk);
		start <= 1'b1;
		req <= '{op: amoXor, laneSize: laneByte, addr: 6'd10, operand: '1};
		@(posedge clk);
		start <= 1'b0;
		hostWe <= 1'b0;
		awaitDone(cycles);
		checkCycles("done delay after edge 2", cycles, 1);
		checkData("oldData", oldData, expOld);
		model[10] = predictWord(amoAdd, laneHalf, expOld, operand);
		@(negedge clk);
		checkLevel("done", done, 1'b0);
		checkLevel("busy", busy, 1'b0);
		readBack(6'd10);
		readBack(6'd11);
	endtask

	task automatic testBackToBack();
		hostWrite(6'd20, {$urandom, $urandom});
		repeat (12)
		begin
			runAmo(amoOp_e'(4'($urandom_range(10, 0))), laneSize_e'(2'($urandom_range(3, 0))),
				6'd20, {$urandom, $urandom});
		end
		readBack(6'd20);
	endtask

	initial
	begin
		void'($urandom(62305));
		failCount = 0;
		start <= 1'b0;
		req <= '0;
		hostWe <= 1'b0;
		hostAddr <= '0;
		hostData <= '0;
		arstN <= 1'b0;
		repeat (5) @(posedge clk);
		arstN <= 1'b1;
		testResetAndSwap();
		testAddLanes();
		testLogicAndShifts();
		testMinMax();
		testBusyRules();
		testBackToBack();
		if (failCount == 0)
		begin
			$display("sim passed");
		end
		else
		begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- tests/amoUnit_properties.sv
// Protocol assertions for the AMO sequencer, attached to every amoSequencer by bind
`timescale 1ns/1ps

module amoUnit_properties
(
	input logic clk,
	input logic arstN,
	input logic start,
	input logic busy,
	input logic done,
	input logic memWe,
	input amoPkg::amoState_e state
);

	import amoPkg::*;

	// ====================
	// Response timing
	// ====================

	doneOneCycle: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// Accepted start gives done on the third edge and not before
	doneLatency: assert property (@(posedge clk) disable iff (!arstN)
		(start && !busy) |-> ##3 (done && !$past(done) && !$past(done, 2)))
		else $error("done did not follow the accepted start by 3 cycles");

	// Busy covers the three cycles of a request and is low once back in stIdle
	busyWindow: assert property (@(posedge clk) disable iff (!arstN)
		(start && !busy) |=> busy [*3] ##1 (!busy && (state == stIdle)))
		else $error("busy not high for exactly the three cycles of a request");

	// ====================
	// State rules
	// ====================

	noWriteInRead: assert property (@(posedge clk) disable iff (!arstN)
		(state == stRead) |-> !memWe)
		else $error("memory written while in stRead");

endmodule

bind amoSequencer amoUnit_properties amoUnit_properties_i
(
	.clk(clk),
	.arstN(arstN),
	.start(start),
	.busy(busy),
	.done(done),
	.memWe(memWe),
	.state(state)
);
